// ==== verilog.f ====
+incdir+hdl
hdl/alu_pkg.sv
hdl/bus_pkg.sv
hdl/alu_ctrl.sv
hdl/alu_operands.sv
hdl/alu_core.sv
hdl/alu_flags.sv
hdl/alu_wb_top.sv
test/alu_wb_asserts.sv
test/alu_wb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module alu_wb_tb -f verilog.f
./obj_dir/Valu_wb_tb | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// ==== test/alu_wb_tb.sv ====
`timescale 1ns/1ps

`include "alu_params.svh"

module alu_wb_tb;

   localparam int ACK_TIMEOUT = 20;
   localparam int RAND_CASES  = 32;
   localparam int MSB         = `ALU_DW - 1;
   localparam int SMAX        = 2 ** (`ALU_DW - 1) - 1;
   localparam int UMAX        = 2 ** `ALU_DW - 1;

   typedef struct {
      string               name;
      logic                c_in;
      logic [`ALU_DW-1:0]  a;
      logic [`ALU_DW-1:0]  b;
      alu_pkg::alu_op_e    op;
      logic [`ALU_DW-1:0]  exp_a;
      alu_pkg::alu_flags_t exp_flags;
   } alu_case_t;

   logic               clk;
   logic               arst_n;
   logic               cyc;
   logic               stb;
   logic               we;
   logic [`ALU_AW-1:0] adr;
   logic [`ALU_DW-1:0] dat_w;
   logic [`ALU_DW-1:0] dat_r;
   logic               ack;

   alu_case_t cases[$];

   alu_wb_top i_alu_wb_top (
      .clk    (clk),
      .arst_n (arst_n),
      .cyc    (cyc),
      .stb    (stb),
      .we     (we),
      .adr    (adr),
      .dat_w  (dat_w),
      .dat_r  (dat_r),
      .ack    (ack)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // --------------------------------------------------
   // Checking
   // --------------------------------------------------

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input logic [`ALU_DW-1:0] exp,
                             input logic [`ALU_DW-1:0] act);
      if (act !== exp)
         stop_on_error($sformatf("Error %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_flags(input string name, input alu_pkg::alu_flags_t exp,
                              input alu_pkg::alu_flags_t act);
      if (act !== exp)
         stop_on_error($sformatf("Error %s expected nvzc=%b actual nvzc=%b", name, exp, act));
   endtask

   function automatic alu_pkg::alu_flags_t status_to_flags(input logic [`ALU_DW-1:0] st);
      alu_pkg::alu_flags_t f;
      f.n = st[`ST_N];
      f.v = st[`ST_V];
      f.z = st[`ST_Z];
      f.c = st[`ST_C];
      return f;
   endfunction

   function automatic logic [`ALU_DW-1:0] op_byte(input alu_pkg::alu_op_e op);
      logic [`ALU_DW-1:0] d;
      d      = '0;
      d[3:0] = op;
      return d;
   endfunction

   // --------------------------------------------------
   // Wishbone master
   // --------------------------------------------------

   // Returns at the falling edge of the ack cycle, where dat_r is stable.
   task automatic wait_ack();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!ack && cycles < ACK_TIMEOUT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!ack)
         stop_on_error("bus cycle not acknowledged");
   endtask

   task automatic wb_write(input bus_pkg::reg_addr_e addr, input logic [`ALU_DW-1:0] data);
      @(posedge clk);
      cyc   <= 1'b1;
      stb   <= 1'b1;
      we    <= 1'b1;
      adr   <= addr;
      dat_w <= data;
      wait_ack();
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
   endtask

   task automatic wb_read(input bus_pkg::reg_addr_e addr, output logic [`ALU_DW-1:0] data);
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we  <= 1'b0;
      adr <= addr;
      wait_ack();
      data = dat_r;
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
   endtask

   // --------------------------------------------------
   // Stimulus table and reference model
   // --------------------------------------------------

   // Flags are given as {n, v, z, c}.
   task automatic add_case(input string name, input logic c_in, input logic [`ALU_DW-1:0] a,
                           input logic [`ALU_DW-1:0] b, input alu_pkg::alu_op_e op,
                           input logic [`ALU_DW-1:0] exp_a, input alu_pkg::alu_flags_t f);
      alu_case_t tc;
      tc.name      = name;
      tc.c_in      = c_in;
      tc.a         = a;
      tc.b         = b;
      tc.op        = op;
      tc.exp_a     = exp_a;
      tc.exp_flags = f;
      cases.push_back(tc);
   endtask

   // V carries over between entries, so the order matters.
   task automatic build_table();
      add_case("and_zero",       1'b1, 8'hF0, 8'h0F, alu_pkg::OP_AND,      8'h00, 4'b0011);
      add_case("and_neg",        1'b0, 8'hF3, 8'h81, alu_pkg::OP_AND,      8'h81, 4'b1000);
      add_case("or_basic",       1'b1, 8'h12, 8'h40, alu_pkg::OP_OR,       8'h52, 4'b0001);
      add_case("eor_zero",       1'b0, 8'h5A, 8'h5A, alu_pkg::OP_EOR,      8'h00, 4'b0010);
      add_case("eor_neg",        1'b1, 8'h0F, 8'hF0, alu_pkg::OP_EOR,      8'hFF, 4'b1001);
      add_case("transfer",       1'b0, 8'h11, 8'h80, alu_pkg::OP_TRANSFER, 8'h80, 4'b1000);
      add_case("adc_ovf",        1'b0, 8'h7F, 8'h01, alu_pkg::OP_ADC,      8'h80, 4'b1100);
      add_case("and_keep_v",     1'b1, 8'hFF, 8'h3C, alu_pkg::OP_AND,      8'h3C, 4'b0101);
      add_case("adc_carry_zero", 1'b0, 8'hFF, 8'h01, alu_pkg::OP_ADC,      8'h00, 4'b0011);
      add_case("adc_cin",        1'b1, 8'h10, 8'h20, alu_pkg::OP_ADC,      8'h31, 4'b0000);
      add_case("adc_neg_ovf",    1'b0, 8'h80, 8'h80, alu_pkg::OP_ADC,      8'h00, 4'b0111);
      add_case("adc_cin_carry",  1'b1, 8'hF0, 8'h0F, alu_pkg::OP_ADC,      8'h00, 4'b0011);
      add_case("cmp_gt",         1'b0, 8'h50, 8'h30, alu_pkg::OP_CMP,      8'h50, 4'b0001);
      add_case("cmp_eq",         1'b0, 8'h42, 8'h42, alu_pkg::OP_CMP,      8'h42, 4'b0011);
      add_case("cmp_lt",         1'b1, 8'h10, 8'h20, alu_pkg::OP_CMP,      8'h10, 4'b1000);
      add_case("asl_c0",         1'b0, 8'h81, 8'h55, alu_pkg::OP_ASL,      8'h02, 4'b0001);
      add_case("asl_c1",         1'b1, 8'h40, 8'h55, alu_pkg::OP_ASL,      8'h80, 4'b1000);
      add_case("lsr_c1",         1'b1, 8'h01, 8'h55, alu_pkg::OP_LSR,      8'h00, 4'b0011);
      add_case("lsr_c0",         1'b0, 8'h82, 8'h55, alu_pkg::OP_LSR,      8'h41, 4'b0000);
      add_case("rol_c1",         1'b1, 8'h80, 8'h55, alu_pkg::OP_ROL,      8'h01, 4'b0001);
      add_case("rol_c0",         1'b0, 8'h40, 8'h55, alu_pkg::OP_ROL,      8'h80, 4'b1000);
      add_case("ror_c1",         1'b1, 8'h02, 8'h55, alu_pkg::OP_ROR,      8'h81, 4'b1000);
      add_case("ror_c0",         1'b0, 8'h01, 8'h55, alu_pkg::OP_ROR,      8'h00, 4'b0011);
      add_case("inc_wrap",       1'b0, 8'hFF, 8'h55, alu_pkg::OP_INC,      8'h00, 4'b0010);
      add_case("dec_wrap",       1'b1, 8'h00, 8'h55, alu_pkg::OP_DEC,      8'hFF, 4'b1001);
      add_case("adc_pos_ovf",    1'b1, 8'h40, 8'h3F, alu_pkg::OP_ADC,      8'h80, 4'b1100);
      add_case("dec_keep_v",     1'b1, 8'h80, 8'h55, alu_pkg::OP_DEC,      8'h7F, 4'b0101);
      add_case("inc_keep_v",     1'b0, 8'h7F, 8'h55, alu_pkg::OP_INC,      8'h80, 4'b1100);
      add_case("or_zero_keep_v", 1'b0, 8'h00, 8'h00, alu_pkg::OP_OR,       8'h00, 4'b0110);
   endtask

   // ADC on the 6502: unsigned range gives C, signed range gives V.
   task automatic adc_model(input logic [`ALU_DW-1:0] a, input logic [`ALU_DW-1:0] b,
                            input logic c, output logic [`ALU_DW-1:0] sum,
                            output alu_pkg::alu_flags_t f);
      int u;
      int s;
      u   = int'(a) + int'(b) + int'(c);
      s   = int'($signed(a)) + int'($signed(b)) + int'(c);
      sum = u[`ALU_DW-1:0];
      f.c = (u > UMAX);
      f.v = (s > SMAX) || (s < -SMAX - 1);
      f.n = sum[MSB];
      f.z = (sum == '0);
   endtask

   // Sets C through the status register, then runs one operation and checks A and the flags.
   task automatic run_case(input alu_case_t tc, input alu_pkg::alu_flags_t prev,
                           input logic both_bits);
      logic [`ALU_DW-1:0]  rd;
      alu_pkg::alu_flags_t exp_c;
      exp_c   = prev;
      exp_c.c = tc.c_in;
      if (tc.c_in)
         wb_write(bus_pkg::ADDR_STATUS, both_bits ? 8'h03 : 8'h01);
      else
         wb_write(bus_pkg::ADDR_STATUS, 8'h02);
      wb_read(bus_pkg::ADDR_STATUS, rd);
      check_flags({tc.name, "_carry"}, exp_c, status_to_flags(rd));

      wb_write(bus_pkg::ADDR_A, tc.a);
      wb_write(bus_pkg::ADDR_B, tc.b);
      wb_write(bus_pkg::ADDR_OP, op_byte(tc.op));

      wb_read(bus_pkg::ADDR_A, rd);
      check_data(tc.name, tc.exp_a, rd);
      wb_read(bus_pkg::ADDR_STATUS, rd);
      check_flags(tc.name, tc.exp_flags, status_to_flags(rd));
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------

   initial
   begin
      logic [`ALU_DW-1:0]  rd;
      logic [31:0]         rnd;
      alu_pkg::alu_flags_t prev;
      alu_case_t           tc;

      void'($urandom(32'h56bb_b6a9));
      arst_n <= 1'b0;
      cyc    <= 1'b0;
      stb    <= 1'b0;
      we     <= 1'b0;
      adr    <= '0;
      dat_w  <= '0;
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;

      wb_read(bus_pkg::ADDR_A, rd);
      check_data("reset_a", 8'h00, rd);
      wb_read(bus_pkg::ADDR_B, rd);
      check_data("reset_b", 8'h00, rd);
      wb_read(bus_pkg::ADDR_STATUS, rd);
      check_data("reset_status", 8'h00, rd);

      build_table();
      prev = '0;
      foreach (cases[i])
      begin
         run_case(cases[i], prev, (i % 2) == 1);
         prev = cases[i].exp_flags;
      end

      for (int i = 0; i < RAND_CASES; i++)
      begin
         rnd     = $urandom;
         tc.name = $sformatf("adc_rand_%0d", i);
         tc.a    = rnd[`ALU_DW-1:0];
         tc.b    = rnd[2*`ALU_DW-1:`ALU_DW];
         tc.c_in = rnd[16];
         tc.op   = alu_pkg::OP_ADC;
         adc_model(tc.a, tc.b, tc.c_in, tc.exp_a, tc.exp_flags);
         run_case(tc, prev, rnd[17]);
         prev = tc.exp_flags;
      end

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// ==== test/alu_wb_asserts.sv ====
`timescale 1ns/1ps

module alu_wb_asserts (
   input logic                 clk,
   input logic                 arst_n,
   input logic                 cyc,
   input logic                 stb,
   input logic                 ack,
   input logic                 start,
   input logic                 valid,
   input bus_pkg::ctrl_state_e state
);

   ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) ack |=> !ack)
      else $error("ack high for two consecutive cycles");

   ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n) ack |-> (cyc && stb))
      else $error("ack outside of an active bus cycle");

   // The core raises valid in WRITEBACK, one cycle after start.
   start_to_valid: assert property (@(posedge clk) disable iff (!arst_n)
                                    start |=> valid && (state == bus_pkg::WRITEBACK))
      else $error("start not followed by valid in the write-back cycle");

endmodule

bind alu_wb_top alu_wb_asserts i_alu_wb_asserts (
   .clk    (clk),
   .arst_n (arst_n),
   .cyc    (cyc),
   .stb    (stb),
   .ack    (ack),
   .start  (start),
   .valid  (valid),
   .state  (i_alu_ctrl.state)
);

// ==== hdl/alu_wb_top.sv ====
`timescale 1ns/1ps

`include "alu_params.svh"

module alu_wb_top (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               cyc,
   input  logic               stb,
   input  logic               we,
   input  logic [`ALU_AW-1:0] adr,
   input  logic [`ALU_DW-1:0] dat_w,
   output logic [`ALU_DW-1:0] dat_r,
   output logic               ack
);

   logic                wr_a;
   logic                wr_b;
   logic                wb_en;
   logic                start;
   logic                c_set;
   logic                c_clr;
   bus_pkg::reg_addr_e  rd_sel;
   alu_pkg::alu_op_e    op;
   logic [`ALU_DW-1:0]  a;
   logic [`ALU_DW-1:0]  b;
   logic [`ALU_DW-1:0]  result;
   logic                carry_out;
   logic                ovf;
   logic                valid;
   logic                c_upd;
   logic                v_upd;
   alu_pkg::alu_flags_t flags;
   logic [`ALU_DW-1:0]  status;

   // Unused status bits read as zero.
   always_comb
   begin
      status          = '0;
      status[`ST_C]   = flags.c;
      status[`ST_Z]   = flags.z;
      status[`ST_V]   = flags.v;
      status[`ST_N]   = flags.n;
   end

   alu_ctrl i_alu_ctrl (
      .clk    (clk),
      .arst_n (arst_n),
      .cyc    (cyc),
      .stb    (stb),
      .we     (we),
      .adr    (adr),
      .dat_w  (dat_w),
      .ack    (ack),
      .wr_a   (wr_a),
      .wr_b   (wr_b),
      .rd_sel (rd_sel),
      .start  (start),
      .op     (op),
      .c_set  (c_set),
      .c_clr  (c_clr),
      .wb_en  (wb_en)
   );

   alu_operands i_alu_operands (
      .clk    (clk),
      .arst_n (arst_n),
      .dat_w  (dat_w),
      .wr_a   (wr_a),
      .wr_b   (wr_b),
      .wb_en  (wb_en),
      .result (result),
      .rd_sel (rd_sel),
      .status (status),
      .a      (a),
      .b      (b),
      .dat_r  (dat_r)
   );

   alu_core i_alu_core (
      .clk       (clk),
      .arst_n    (arst_n),
      .start     (start),
      .op        (op),
      .a         (a),
      .b         (b),
      .c_in      (flags.c),
      .result    (result),
      .carry_out (carry_out),
      .ovf       (ovf),
      .valid     (valid),
      .c_upd     (c_upd),
      .v_upd     (v_upd)
   );

   alu_flags i_alu_flags (
      .clk       (clk),
      .arst_n    (arst_n),
      .valid     (valid),
      .result    (result),
      .carry_out (carry_out),
      .ovf       (ovf),
      .c_upd     (c_upd),
      .v_upd     (v_upd),
      .c_set     (c_set),
      .c_clr     (c_clr),
      .flags     (flags)
   );

endmodule

// ==== hdl/alu_flags.sv ====
`timescale 1ns/1ps

`include "alu_params.svh"

module alu_flags (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                valid,
   input  logic [`ALU_DW-1:0]  result,
   input  logic                carry_out,
   input  logic                ovf,
   input  logic                c_upd,
   input  logic                v_upd,
   input  logic                c_set,
   input  logic                c_clr,
   output alu_pkg::alu_flags_t flags
);

   // --------------------------------------------------
   // Status register
   // --------------------------------------------------

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         flags <= '0;
      end
      else if (c_set)
      begin
         flags.c <= 1'b1;
      end
      else if (c_clr)
      begin
         flags.c <= 1'b0;
      end
      else if (valid)
      begin
         // N and Z follow every result; C and V only when the operation owns them.
         flags.n <= result[`ALU_DW-1];
         flags.z <= (result == '0);

         if (c_upd)
            flags.c <= carry_out;

         if (v_upd)
            flags.v <= ovf;
      end
   end

endmodule

// ==== hdl/alu_core.sv ====
`timescale 1ns/1ps

`include "alu_params.svh"

module alu_core (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                start,
   input  alu_pkg::alu_op_e    op,
   input  logic [`ALU_DW-1:0]  a,
   input  logic [`ALU_DW-1:0]  b,
   input  logic                c_in,
   output logic [`ALU_DW-1:0]  result,
   output logic                carry_out,
   output logic                ovf,
   output logic                valid,
   output logic                c_upd,
   output logic                v_upd
);

   localparam int MSB = `ALU_DW - 1;

   logic [`ALU_DW:0]   sum9;
   logic [`ALU_DW:0]   diff9;
   logic [`ALU_DW-1:0] res_nxt;
   logic               cout_nxt;
   logic               ovf_nxt;
   logic               cu_nxt;
   logic               vu_nxt;

   assign sum9  = {1'b0, a} + {1'b0, b} + (`ALU_DW+1)'(c_in);
   assign diff9 = {1'b0, a} - {1'b0, b};

   // --------------------------------------------------
   // Operation decode
   // --------------------------------------------------

   always_comb
   begin
      res_nxt  = a;
      cout_nxt = c_in;
      ovf_nxt  = 1'b0;
      cu_nxt   = 1'b0;
      vu_nxt   = 1'b0;

      case (op)
         alu_pkg::OP_TRANSFER:
            res_nxt = b;
         alu_pkg::OP_AND:
            res_nxt = a & b;
         alu_pkg::OP_OR:
            res_nxt = a | b;
         alu_pkg::OP_EOR:
            res_nxt = a ^ b;
         alu_pkg::OP_ADC:
         begin
            res_nxt  = sum9[MSB:0];
            cout_nxt = sum9[`ALU_DW];
            // Two operands of one sign giving a sum of the other sign.
            ovf_nxt  = (a[MSB] == b[MSB]) && (sum9[MSB] != a[MSB]);
            cu_nxt   = 1'b1;
            vu_nxt   = 1'b1;
         end
         alu_pkg::OP_INC:
            res_nxt = a + 1'b1;
         alu_pkg::OP_DEC:
            res_nxt = a - 1'b1;
         alu_pkg::OP_CMP:
         begin
            // The 6502 carry after a compare means no borrow.
            res_nxt  = diff9[MSB:0];
            cout_nxt = !diff9[`ALU_DW];
            cu_nxt   = 1'b1;
         end
         alu_pkg::OP_ASL:
         begin
            res_nxt  = {a[MSB-1:0], 1'b0};
            cout_nxt = a[MSB];
            cu_nxt   = 1'b1;
         end
         alu_pkg::OP_LSR:
         begin
            res_nxt  = {1'b0, a[MSB:1]};
            cout_nxt = a[0];
            cu_nxt   = 1'b1;
         end
         alu_pkg::OP_ROL:
         begin
            res_nxt  = {a[MSB-1:0], c_in};
            cout_nxt = a[MSB];
            cu_nxt   = 1'b1;
         end
         alu_pkg::OP_ROR:
         begin
            res_nxt  = {c_in, a[MSB:1]};
            cout_nxt = a[0];
            cu_nxt   = 1'b1;
         end
         default:
            res_nxt = a;
      endcase
   end

   // --------------------------------------------------
   // Output registers
   // --------------------------------------------------

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         valid <= 1'b0;
         c_upd <= 1'b0;
         v_upd <= 1'b0;
      end
      else
      begin
         valid <= start;
         if (start)
         begin
            c_upd <= cu_nxt;
            v_upd <= vu_nxt;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         result    <= res_nxt;
         carry_out <= cout_nxt;
         ovf       <= ovf_nxt;
      end
   end

endmodule

// ==== hdl/alu_operands.sv ====
`timescale 1ns/1ps

`include "alu_params.svh"

module alu_operands (
   input  logic                clk,
   input  logic                arst_n,
   input  logic [`ALU_DW-1:0]  dat_w,
   input  logic                wr_a,
   input  logic                wr_b,
   input  logic                wb_en,
   input  logic [`ALU_DW-1:0]  result,
   input  bus_pkg::reg_addr_e  rd_sel,
   input  logic [`ALU_DW-1:0]  status,
   output logic [`ALU_DW-1:0]  a,
   output logic [`ALU_DW-1:0]  b,
   output logic [`ALU_DW-1:0]  dat_r
);

   // --------------------------------------------------
   // Accumulator and operand B
   // --------------------------------------------------

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         a <= '0;
         b <= '0;
      end
      else
      begin
         // Bus writes and write-back never coincide.
         if (wb_en)
            a <= result;
         else if (wr_a)
            a <= dat_w;

         if (wr_b)
            b <= dat_w;
      end
   end

   // --------------------------------------------------
   // Read data
   // --------------------------------------------------

   always_comb
   begin
      case (rd_sel)
         bus_pkg::ADDR_A:
            dat_r = a;
         bus_pkg::ADDR_B:
            dat_r = b;
         bus_pkg::ADDR_STATUS:
            dat_r = status;
         default:
            dat_r = '0;
      endcase
   end

endmodule

// ==== hdl/alu_ctrl.sv ====
`timescale 1ns/1ps

`include "alu_params.svh"

module alu_ctrl (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                cyc,
   input  logic                stb,
   input  logic                we,
   input  logic [`ALU_AW-1:0]  adr,
   input  logic [`ALU_DW-1:0]  dat_w,
   output logic                ack,
   output logic                wr_a,
   output logic                wr_b,
   output bus_pkg::reg_addr_e  rd_sel,
   output logic                start,
   output alu_pkg::alu_op_e    op,
   output logic                c_set,
   output logic                c_clr,
   output logic                wb_en
);

   bus_pkg::ctrl_state_e state;
   bus_pkg::reg_addr_e   addr;
   alu_pkg::alu_op_e     op_dec;
   logic                 accept;
   logic                 wr_acc;

   assign addr = bus_pkg::reg_addr_e'(adr);

   // A new access is only taken in IDLE, so a running operation holds off the bus.
   assign accept = cyc && stb && (state == bus_pkg::IDLE);
   assign wr_acc = accept && we;

   always_comb
   begin
      if (dat_w[3:0] > 4'(alu_pkg::OP_ROR))
         op_dec = alu_pkg::OP_NOP;
      else
         op_dec = alu_pkg::alu_op_e'(dat_w[3:0]);
   end

   // --------------------------------------------------
   // Sequencer
   // --------------------------------------------------

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state <= bus_pkg::IDLE;
         op    <= alu_pkg::OP_NOP;
      end
      else
      begin
         case (state)
            bus_pkg::IDLE:
            begin
               if (wr_acc && (addr == bus_pkg::ADDR_OP))
               begin
                  op    <= op_dec;
                  state <= bus_pkg::EXEC;
               end
               else if (accept)
               begin
                  state <= bus_pkg::ACK;
               end
            end
            bus_pkg::EXEC:
            begin
               state <= bus_pkg::WRITEBACK;
            end
            bus_pkg::WRITEBACK:
            begin
               state <= bus_pkg::ACK;
            end
            default:
            begin
               state <= bus_pkg::IDLE;
            end
         endcase
      end
   end

   // --------------------------------------------------
   // Single-cycle strobes
   // --------------------------------------------------

   assign ack   = (state == bus_pkg::ACK);
   assign start = (state == bus_pkg::EXEC);

   // CMP only sets flags and NOP has nothing to store.
   assign wb_en = (state == bus_pkg::WRITEBACK) &&
                  (op != alu_pkg::OP_CMP) && (op != alu_pkg::OP_NOP);

   assign wr_a = wr_acc && (addr == bus_pkg::ADDR_A);
   assign wr_b = wr_acc && (addr == bus_pkg::ADDR_B);

   // Setting the carry takes priority when both bits are written.
   assign c_set = wr_acc && (addr == bus_pkg::ADDR_STATUS) && dat_w[0];
   assign c_clr = wr_acc && (addr == bus_pkg::ADDR_STATUS) && dat_w[1] && !dat_w[0];

   // The master holds adr until ack, so the read select follows it directly.
   assign rd_sel = addr;

endmodule

// ==== hdl/bus_pkg.sv ====
`include "alu_params.svh"

package bus_pkg;

   // Word addresses of the Wishbone register map.
   typedef enum logic [`ALU_AW-1:0] {
      ADDR_A      = 3'd0,
      ADDR_B      = 3'd1,
      ADDR_OP     = 3'd2,
      ADDR_STATUS = 3'd3
   } reg_addr_e;

   // Bus controller states.
   typedef enum logic [1:0] {
      IDLE      = 2'd0,
      EXEC      = 2'd1,
      WRITEBACK = 2'd2,
      ACK       = 2'd3
   } ctrl_state_e;

endpackage

// ==== hdl/alu_pkg.sv ====
package alu_pkg;

   // Opcodes accepted through the opcode register.
   // Codes above OP_ROR are executed as OP_NOP.
   typedef enum logic [3:0] {
      OP_NOP      = 4'd0,
      OP_TRANSFER = 4'd1,
      OP_AND      = 4'd2,
      OP_OR       = 4'd3,
      OP_EOR      = 4'd4,
      OP_ADC      = 4'd5,
      OP_INC      = 4'd6,
      OP_DEC      = 4'd7,
      OP_CMP      = 4'd8,
      OP_ASL      = 4'd9,
      OP_LSR      = 4'd10,
      OP_ROL      = 4'd11,
      OP_ROR      = 4'd12
   } alu_op_e;

   // Processor status flags kept by the coprocessor.
   typedef struct packed {
      logic n;
      logic v;
      logic z;
      logic c;
   } alu_flags_t;

endpackage

// ==== hdl/alu_params.svh ====
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// --------------------------------------------------
// Datapath and bus widths
// --------------------------------------------------

// Width of the accumulator, operand B and the bus data.
`define ALU_DW 8

// Wishbone word address width, covering the register map.
`define ALU_AW 3

// --------------------------------------------------
// Status byte layout, as on the 6502
// --------------------------------------------------

`define ST_C 0
`define ST_Z 1
`define ST_V 6
`define ST_N 7

`endif
